// ==== hw/sprite_pkg.sv ====
// fixed config of 4 sprites of 8x8 with a 2-bit sprite kind; palette entries 216..255 read as black
package sprite_pkg;

    typedef logic [11:0] coord_t;
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [6:0]  addr_t;
    typedef logic [1:0]  sprite_id_t;
    typedef logic [7:0]  pal_idx_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        coord_t     x;
        coord_t     y;
        sprite_id_t sprite;
        logic       active;
    } object_t;

    typedef struct packed {
        hcount_t hcount;
        vcount_t vcount;
        logic    active_video;
        logic    hs_n;
        logic    vs_n;
    } scan_t;

    typedef struct packed {
        logic       hit;
        sprite_id_t sprite;
        logic [2:0] row;
        logic [2:0] col;
    } hit_t;

    localparam int sprite_size  = 8;
    localparam int sprite_count = 4;

    localparam rgb_t bg_reset_color = 24'h008000;
    localparam int   bg_addr        = 0;
    localparam int   first_obj_addr = 1;

    // object word layout
    localparam int obj_x_lsb      = 20;
    localparam int obj_y_lsb      = 8;
    localparam int obj_sprite_lsb = 2;
    localparam int obj_active_bit = 1;

    // 6x6x6 colour cube
    localparam int         palette_levels = 6;
    localparam logic [7:0] palette_step   = 8'h33;
    localparam int         palette_used   = 216;

    // pipeline contents while blanked or in reset
    localparam scan_t scan_blank = '{hcount: '0, vcount: '0, active_video: 1'b0,
                                     hs_n: 1'b1, vs_n: 1'b1};

endpackage

// ==== hw/vga_timing.sv ====
// h total must stay within 2048 cycles and v total within 1024 lines
`timescale 1ns/10ps

module vga_timing #(
    parameter int h_active = 1280,
    parameter int h_front  = 32,
    parameter int h_sync   = 192,
    parameter int h_back   = 96,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  logic              clk,
    input  logic              reset,
    output sprite_pkg::scan_t scan
);
    import sprite_pkg::*;

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    localparam hcount_t h_last       = hcount_t'(h_total - 1);
    localparam vcount_t v_last       = vcount_t'(v_total - 1);
    localparam hcount_t h_sync_start = hcount_t'(h_active + h_front);
    localparam hcount_t h_sync_end   = hcount_t'(h_active + h_front + h_sync);
    localparam vcount_t v_sync_start = vcount_t'(v_active + v_front);
    localparam vcount_t v_sync_end   = vcount_t'(v_active + v_front + v_sync);

    hcount_t hcount;
    vcount_t vcount;
    logic    end_of_line;
    logic    end_of_frame;

    assign end_of_line  = hcount == h_last;
    assign end_of_frame = vcount == v_last;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            hcount <= end_of_line ? '0 : hcount + 1'b1;
            if (end_of_line) begin
                vcount <= end_of_frame ? '0 : vcount + 1'b1; // one line per h wrap
            end
        end
    end

    always_comb begin
        scan.hcount       = hcount;
        scan.vcount       = vcount;
        scan.active_video = (hcount < hcount_t'(h_active)) && (vcount < vcount_t'(v_active));
        scan.hs_n         = !((hcount >= h_sync_start) && (hcount < h_sync_end));
        scan.vs_n         = !((vcount >= v_sync_start) && (vcount < v_sync_end));
    end

endmodule

// ==== hw/object_table.sv ====
// plain write strobe, no readback; addresses past max_objects are dropped silently
`timescale 1ns/10ps

module object_table #(
    parameter int max_objects = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                chipselect,
    input  logic                write,
    input  sprite_pkg::addr_t   address,
    input  logic [31:0]         writedata,
    output sprite_pkg::rgb_t    background,
    output sprite_pkg::object_t objects [max_objects]
);
    import sprite_pkg::*;

    object_t new_obj;
    logic    wr_en;

    assign wr_en = chipselect && write;

    // split the word by the register map and ignore sprite kind bits [7:4]
    always_comb begin
        new_obj.x      = writedata[obj_x_lsb +: $bits(coord_t)];
        new_obj.y      = writedata[obj_y_lsb +: $bits(coord_t)];
        new_obj.sprite = writedata[obj_sprite_lsb +: $bits(sprite_id_t)];
        new_obj.active = writedata[obj_active_bit];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            background <= bg_reset_color;
        end else if (wr_en && address == addr_t'(bg_addr)) begin
            background <= writedata[$bits(rgb_t)-1:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < max_objects; i++) begin
                objects[i] <= '0; // inactive at 0,0
            end
        end else if (wr_en) begin
            for (int i = 0; i < max_objects; i++) begin
                if (address == addr_t'(first_obj_addr + i)) begin
                    objects[i] <= new_obj;
                end
            end
        end
    end

endmodule

// ==== hw/object_scan.sv ====
// search is fully combinational over all objects in one cycle; depth grows with max_objects
`timescale 1ns/10ps

module object_scan #(
    parameter int max_objects = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  sprite_pkg::scan_t   scan_in,
    input  sprite_pkg::object_t objects [max_objects],
    output sprite_pkg::hit_t    hit,
    output sprite_pkg::scan_t   scan_out
);
    import sprite_pkg::*;

    logic [12:0] column;
    logic [12:0] line;
    logic [12:0] col_off [max_objects];
    logic [12:0] row_off [max_objects];
    hit_t        hit_next;

    // pixel column runs at half the counter rate
    assign column = {3'b000, scan_in.hcount[10:1]};
    assign line   = {3'b000, scan_in.vcount};

    // offsets wrap to large values when the pixel lies left of or above the object
    always_comb begin
        for (int i = 0; i < max_objects; i++) begin
            col_off[i] = column - {1'b0, objects[i].x};
            row_off[i] = line - {1'b0, objects[i].y};
        end
    end

    // ascending loop, so the last match is the highest index
    always_comb begin
        hit_next = '0;
        for (int i = 0; i < max_objects; i++) begin
            if (objects[i].active
                && col_off[i] < 13'(sprite_size)
                && row_off[i] < 13'(sprite_size)) begin
                hit_next.hit    = 1'b1;
                hit_next.sprite = objects[i].sprite;
                hit_next.row    = row_off[i][2:0];
                hit_next.col    = col_off[i][2:0];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit      <= '0;
            scan_out <= scan_blank;
        end else begin
            hit      <= hit_next;
            scan_out <= scan_in;
        end
    end

endmodule

// ==== hw/sprite_fetch.sv ====
// loads 64-bit ROM words from hw/sprite_rom.mem relative to the run directory
`timescale 1ns/10ps

module sprite_fetch (
    input  logic                 clk,
    input  logic                 reset,
    input  sprite_pkg::hit_t     hit,
    input  sprite_pkg::scan_t    scan_in,
    output sprite_pkg::pal_idx_t pixel_index,
    output logic                 pixel_hit,
    output sprite_pkg::scan_t    scan_out
);
    import sprite_pkg::*;

    localparam int word_w    = sprite_size * $bits(pal_idx_t);
    localparam int rom_depth = sprite_count * sprite_size;

    logic [word_w-1:0] rom [rom_depth];
    logic [word_w-1:0] row_word;
    pal_idx_t          col_byte;

    initial begin
        $readmemh("hw/sprite_rom.mem", rom);
    end

    assign row_word = rom[{hit.sprite, hit.row}]; // sprite*8 + row

    // col 0 sits in the top byte
    assign col_byte = row_word[(sprite_size - 1 - int'(hit.col)) * $bits(pal_idx_t)
                               +: $bits(pal_idx_t)];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pixel_index <= '0;
            pixel_hit   <= 1'b0;
            scan_out    <= scan_blank;
        end else begin
            pixel_index <= col_byte;
            pixel_hit   <= hit.hit;
            scan_out    <= scan_in;
        end
    end

endmodule

// ==== hw/pixel_compositor.sv ====
// black palette colours are transparent, so sprites cannot draw pure black
`timescale 1ns/10ps

module pixel_compositor (
    input  logic                 clk,
    input  logic                 reset,
    input  sprite_pkg::rgb_t     background,
    input  sprite_pkg::pal_idx_t pixel_index,
    input  logic                 pixel_hit,
    input  sprite_pkg::scan_t    scan_in,
    output logic [7:0]           vga_r,
    output logic [7:0]           vga_g,
    output logic [7:0]           vga_b,
    output logic                 vga_clk,
    output logic                 vga_hs,
    output logic                 vga_vs,
    output logic                 vga_blank_n
);
    import sprite_pkg::*;

    rgb_t pal_color;
    rgb_t pixel_color;

    // colour cube rule with entries past the cube left black
    always_comb begin
        pal_color = '0;
        if (int'(pixel_index) < palette_used) begin
            pal_color.r = 8'(int'(pixel_index) / (palette_levels * palette_levels)
                             * palette_step);
            pal_color.g = 8'((int'(pixel_index) / palette_levels) % palette_levels
                             * palette_step);
            pal_color.b = 8'(int'(pixel_index) % palette_levels * palette_step);
        end
    end

    always_comb begin
        if (!scan_in.active_video) begin
            pixel_color = '0;
        end else if (pixel_hit && pal_color != '0) begin
            pixel_color = pal_color;
        end else begin
            pixel_color = background;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {vga_r, vga_g, vga_b} <= '0;
            vga_clk               <= 1'b0;
            vga_hs                <= 1'b1;
            vga_vs                <= 1'b1;
            vga_blank_n           <= 1'b0;
        end else begin
            {vga_r, vga_g, vga_b} <= pixel_color;
            vga_clk               <= scan_in.hcount[0]; // 25 MHz pixel strobe
            vga_hs                <= scan_in.hs_n;
            vga_vs                <= scan_in.vs_n;
            vga_blank_n           <= scan_in.active_video;
        end
    end

endmodule

// ==== hw/vga_sprite_top.sv ====
// pins lag the raster counters by exactly 3 clocks; max_objects from 1 to 126
`timescale 1ns/10ps

module vga_sprite_top #(
    parameter int max_objects = 8,
    parameter int h_active    = 1280,
    parameter int h_front     = 32,
    parameter int h_sync      = 192,
    parameter int h_back      = 96,
    parameter int v_active    = 480,
    parameter int v_front     = 10,
    parameter int v_sync      = 2,
    parameter int v_back      = 33
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              chipselect,
    input  logic              write,
    input  sprite_pkg::addr_t address,
    input  logic [31:0]       writedata,
    output logic [7:0]        vga_r,
    output logic [7:0]        vga_g,
    output logic [7:0]        vga_b,
    output logic              vga_clk,
    output logic              vga_hs,
    output logic              vga_vs,
    output logic              vga_blank_n,
    output logic              vga_sync_n
);
    import sprite_pkg::*;

    rgb_t     background;
    object_t  objects [max_objects];
    scan_t    scan_s0;
    scan_t    scan_s1;
    scan_t    scan_s2;
    hit_t     hit_s1;
    pal_idx_t index_s2;
    logic     hit_s2;

    assign vga_sync_n = 1'b0; // no sync on green

    object_table #(
        .max_objects (max_objects)
    ) u_table (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .background (background),
        .objects    (objects)
    );

    vga_timing #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) u_timing (
        .clk   (clk),
        .reset (reset),
        .scan  (scan_s0)
    );

    object_scan #(
        .max_objects (max_objects)
    ) u_scan (
        .clk      (clk),
        .reset    (reset),
        .scan_in  (scan_s0),
        .objects  (objects),
        .hit      (hit_s1),
        .scan_out (scan_s1)
    );

    sprite_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .hit         (hit_s1),
        .scan_in     (scan_s1),
        .pixel_index (index_s2),
        .pixel_hit   (hit_s2),
        .scan_out    (scan_s2)
    );

    pixel_compositor u_comp (
        .clk         (clk),
        .reset       (reset),
        .background  (background),
        .pixel_index (index_s2),
        .pixel_hit   (hit_s2),
        .scan_in     (scan_s2),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n)
    );

endmodule

// ==== testbench/tb_vga_sprite.sv ====
// run from the project root so hw/sprite_rom.mem resolves; 80x30 counter frame, 8 objects
`timescale 1ns/10ps

module tb_vga_sprite;

    localparam int h_active     = 64;
    localparam int h_front      = 4;
    localparam int h_sync       = 8;
    localparam int h_back       = 4;
    localparam int v_active     = 24;
    localparam int v_front      = 2;
    localparam int v_sync       = 2;
    localparam int v_back       = 2;
    localparam int h_total      = h_active + h_front + h_sync + h_back;
    localparam int v_total      = v_active + v_front + v_sync + v_back;
    localparam int frame_cycles = h_total * v_total;
    localparam int latency      = 3;

    logic        clk = 1'b0;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [6:0]  address;
    logic [31:0] writedata;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_sync_n;

    logic [63:0] rom_model [32];
    logic [23:0] shadow_bg;
    int          obj_x [8];
    int          obj_y [8];
    int          obj_kind [8];
    logic        obj_active [8];
    int          cyc = 0;
    logic        counting;
    logic        timed_out;
    integer      seed = 32'hdb65ce2b;
    int          checks;
    int          errors;
    int          tests;
    int          test_checks;
    int          test_errors;

    vga_sprite_top #(
        .max_objects (8),
        .h_active    (h_active),
        .h_front     (h_front),
        .h_sync      (h_sync),
        .h_back      (h_back),
        .v_active    (v_active),
        .v_front     (v_front),
        .v_sync      (v_sync),
        .v_back      (v_back)
    ) uut (.*);

    always #10 clk = ~clk;

    // cycles since the reset release edge
    always @(posedge clk) cyc <= counting ? cyc + 1 : 0;

    initial $readmemh("hw/sprite_rom.mem", rom_model);

    function automatic logic [23:0] palette_rgb(input int idx);
        int r;
        int g;
        int b;
        if (idx >= 216) return 24'h0; // outside the 6x6x6 cube
        r = (idx / 36) * 51;
        g = ((idx / 6) % 6) * 51;
        b = (idx % 6) * 51;
        return {r[7:0], g[7:0], b[7:0]};
    endfunction

    function automatic logic [23:0] expected_rgb(input int h, input int v);
        int          column;
        int          hit_idx;
        int          row;
        int          col;
        logic [63:0] word;
        logic [23:0] color;
        if (h >= h_active || v >= v_active) return 24'h0;
        column  = h / 2;
        hit_idx = -1;
        for (int i = 0; i < 8; i++) begin
            if (obj_active[i] && column >= obj_x[i] && column < obj_x[i] + 8
                && v >= obj_y[i] && v < obj_y[i] + 8) begin
                hit_idx = i; // later index wins
            end
        end
        if (hit_idx < 0) return shadow_bg;
        row   = v - obj_y[hit_idx];
        col   = column - obj_x[hit_idx];
        word  = rom_model[obj_kind[hit_idx] * 8 + row];
        color = palette_rgb(int'(word[(7 - col) * 8 +: 8]));
        return (color == 24'h0) ? shadow_bg : color;
    endfunction

    function automatic logic [31:0] obj_word(input int x, input int y, input int kind,
                                             input logic active, input logic [3:0] junk);
        logic [31:0] w;
        w = {x[11:0], y[11:0], junk, kind[1:0], active, junk[0]}; // [7:4] and [0] ignored
        return w;
    endfunction

    task automatic pick_random(input int limit, output int value);
        value = ($random(seed) & 32'h7fffffff) % limit;
    endtask

    task automatic compare_rgb(input int h, input int v, input logic [23:0] exp_val,
                               input logic [23:0] got);
        checks++;
        test_checks++;
        assert (got === exp_val) else begin
            $display("ERR %0t: rgb at h=%0d v=%0d expected %h got %h", $time, h, v,
                     exp_val, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_bit(input string what, input int h, input int v,
                               input logic exp_val, input logic got);
        checks++;
        test_checks++;
        assert (got === exp_val) else begin
            $display("ERR %0t: %s at h=%0d v=%0d expected %b got %b", $time, what, h, v,
                     exp_val, got);
            errors++;
            test_errors++;
        end
    endtask

    // pins after cycle n show the counters of cycle n-3
    task automatic sample_pins();
        int          n;
        int          h;
        int          v;
        logic [23:0] exp_rgb;
        logic        exp_hs;
        logic        exp_vs;
        logic        exp_blank_n;
        logic        exp_clk;
        if (cyc < latency) begin
            h           = -1;
            v           = -1;
            exp_rgb     = 24'h0;
            exp_hs      = 1'b1;
            exp_vs      = 1'b1;
            exp_blank_n = 1'b0;
            exp_clk     = 1'b0;
        end else begin
            n           = cyc - latency;
            h           = n % h_total;
            v           = (n / h_total) % v_total;
            exp_rgb     = expected_rgb(h, v);
            exp_hs      = !(h >= h_active + h_front && h < h_active + h_front + h_sync);
            exp_vs      = !(v >= v_active + v_front && v < v_active + v_front + v_sync);
            exp_blank_n = (h < h_active) && (v < v_active);
            exp_clk     = h[0];
        end
        compare_rgb(h, v, exp_rgb, {vga_r, vga_g, vga_b});
        compare_bit("vga_hs", h, v, exp_hs, vga_hs);
        compare_bit("vga_vs", h, v, exp_vs, vga_vs);
        compare_bit("vga_blank_n", h, v, exp_blank_n, vga_blank_n);
        compare_bit("vga_clk", h, v, exp_clk, vga_clk);
        compare_bit("vga_sync_n", h, v, 1'b0, vga_sync_n);
    endtask

    task automatic verify_frames(input int frames);
        for (int i = 0; i < frames * frame_cycles; i++) begin
            @(negedge clk);
            sample_pins();
        end
    endtask

    // returns on the last pixel of a frame, so the next sample starts a fresh one
    task automatic sync_to_frame();
        int waited;
        waited = 0;
        repeat (4) @(negedge clk); // let the last write reach the pins
        while (!(cyc >= latency && (cyc - latency) % frame_cycles == frame_cycles - 1)) begin
            if (waited >= 2 * frame_cycles) begin
                $display("timeout: no frame boundary seen within %0d cycles", waited);
                timed_out = 1'b1;
                return;
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic reg_write(input logic [6:0] addr, input logic [31:0] data, input logic cs);
        int k;
        @(posedge clk);
        chipselect <= cs;
        write      <= 1'b1;
        address    <= addr;
        writedata  <= data;
        @(posedge clk);
        chipselect <= 1'b0;
        write      <= 1'b0;
        k = int'(addr);
        if (cs && k == 0) begin
            shadow_bg = data[23:0];
        end else if (cs && k <= 8) begin
            obj_x[k-1]      = int'(data[31:20]);
            obj_y[k-1]      = int'(data[19:8]);
            obj_kind[k-1]   = int'(data[3:2]);
            obj_active[k-1] = data[1];
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        tests++;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic reset_and_fill();
        repeat (5) begin
            @(posedge clk);
            @(negedge clk);
            sample_pins();
        end
        @(posedge clk);
        reset    <= 1'b0;
        counting <= 1'b1;
        verify_frames(1); // pipeline fill, then frame 0 with the reset colour
        report_test("reset");
    endtask

    task automatic background_write();
        reg_write(7'd0, 32'ha51f2e3d, 1'b1);
        sync_to_frame();
        if (!timed_out) verify_frames(1);
        report_test("background write");
    endtask

    task automatic single_objects();
        int x;
        int y;
        int slot;
        for (int k = 1; k <= 8; k++) begin
            reg_write(7'(k), 32'h0, 1'b1);
        end
        for (int kind = 0; kind < 4 && !timed_out; kind++) begin
            pick_random(25, x);
            pick_random(17, y);
            pick_random(8, slot);
            reg_write(7'(slot + 1), obj_word(x, y, kind, 1'b1, 4'(kind * 5)), 1'b1);
            sync_to_frame();
            if (!timed_out) verify_frames(1);
            reg_write(7'(slot + 1), 32'h0, 1'b1);
        end
        report_test("single object");
    endtask

    task automatic priority_and_inactive();
        reg_write(7'd2, obj_word(10, 8, 2, 1'b1, 4'h0), 1'b1);
        reg_write(7'd5, obj_word(13, 10, 0, 1'b1, 4'h0), 1'b1); // box over the gradient
        reg_write(7'd7, obj_word(4, 4, 1, 1'b0, 4'hf), 1'b1);
        reg_write(7'd9, obj_word(0, 0, 3, 1'b1, 4'h0), 1'b1);
        reg_write(7'd127, obj_word(20, 2, 3, 1'b1, 4'h0), 1'b1);
        reg_write(7'd1, obj_word(0, 0, 3, 1'b1, 4'h0), 1'b0); // strobe without chipselect
        sync_to_frame();
        if (!timed_out) verify_frames(1);
        report_test("priority and inactive");
    endtask

    task automatic sync_timing();
        sync_to_frame();
        if (!timed_out) verify_frames(2);
        report_test("sync and blank timing");
    endtask

    initial begin
        reset      <= 1'b1;
        chipselect <= 1'b0;
        write      <= 1'b0;
        address    <= '0;
        writedata  <= '0;
        counting   <= 1'b0;
        timed_out = 1'b0;
        checks = 0;
        errors = 0;
        tests = 0;
        test_checks = 0;
        test_errors = 0;
        shadow_bg = 24'h008000;
        for (int i = 0; i < 8; i++) begin
            obj_x[i]      = 0;
            obj_y[i]      = 0;
            obj_kind[i]   = 0;
            obj_active[i] = 1'b0;
        end
        reset_and_fill();
        if (!timed_out) background_write();
        if (!timed_out) single_objects();
        if (!timed_out) priority_and_inactive();
        if (!timed_out) sync_timing();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hw/sprite_rom.mem ====
// one 64-bit word per sprite row, 8 palette indices with col 0 in the top byte
// rows 0-7 sprite 0, 8-15 sprite 1, 16-23 sprite 2, 24-31 sprite 3
B4B4B4B4B4B4B4B4
B4000000000000B4
B4002B2B2B2B00B4
B4002B07072B00B4
B4002B07072B00B4
B4002B2B2B2B00B4
B4000000000000B4
B4B4B4B4B4B4B4B4
000000E0E0000000
0000E01E1EE00000
00E01E24241EE000
E01E24FFFF241EE0
E01E24FFFF241EE0
00E01E24241EE000
0000E01E1EE00000
000000E0E0000000
0102030405060708
090A0B0C0D0E0F10
1112131415161718
191A1B1C1D1E1F20
2122232425262728
292A2B2C2D2E2F30
3132333435363738
393A3B3C3D3E3F40
D7D8D7D8D7D8D7D8
D8D7D8D7D8D7D8D7
D7D8D7D8D7D8D7D8
D8D7D8D7D8D7D8D7
D7D8D7D8D7D8D7D8
D8D7D8D7D8D7D8D7
D7D8D7D8D7D8D7D8
D8D7D8D7D8D7D8D7

// ==== filelist.f ====
hw/sprite_pkg.sv
hw/vga_timing.sv
hw/object_table.sv
hw/object_scan.sv
hw/sprite_fetch.sv
hw/pixel_compositor.sv
hw/vga_sprite_top.sv
testbench/tb_vga_sprite.sv

// ==== run.sh ====
#!/bin/sh
# build and run from the project root so the ROM image path resolves
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_vga_sprite -Mdir obj_dir
./obj_dir/Vtb_vga_sprite > sim.log 2>&1 || true
cat sim.log
if grep -q "^Test completed successfully$" sim.log; then
    exit 0
else
    exit 1
fi
